// ==== logic/cache_pkg.sv ====
package cache_pkg;

	// address and data widths
	localparam int ADDR_WIDTH  = 32;
	localparam int DATA_WIDTH  = 32;
	localparam int INDEX_WIDTH = 4;
	localparam int OFFSET_BITS = 2;
	localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_BITS;
	localparam int LINES       = 1 << INDEX_WIDTH;

	// flow control
	localparam int CPU_CREDITS = 2;
	localparam int MEM_CREDITS = 2;
	localparam int QPTR_WIDTH  = $clog2(CPU_CREDITS);
	localparam int QCNT_WIDTH  = $clog2(CPU_CREDITS + 1);
	localparam int MCNT_WIDTH  = $clog2(MEM_CREDITS + 1);

	typedef logic [ADDR_WIDTH-1:0]  addr_t;
	typedef logic [DATA_WIDTH-1:0]  word_t;
	typedef logic [TAG_WIDTH-1:0]   tag_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK,
		ST_FILL_REQ,
		ST_FILL_WAIT,
		ST_FLUSH_SCAN,
		ST_FLUSH_WB,
		ST_FLUSH_DONE
	} ctrl_state_t;

endpackage

// ==== logic/cache_ctrl_if.sv ====
`timescale 1ns/10ps

interface cache_ctrl_if;

	// strobes from the controller
	logic fill_en;
	logic cpu_wr_en;
	logic wb_sel;
	logic clean_en;
	logic flush_active;
	logic flush_step;
	logic flush_clear;

	// lookup status back from the datapath
	logic hit;
	logic dirty;
	logic flush_last;

	modport controller (
		output fill_en, cpu_wr_en, wb_sel, clean_en,
		output flush_active, flush_step, flush_clear,
		input  hit, dirty, flush_last
	);

	modport datapath (
		input  fill_en, cpu_wr_en, wb_sel, clean_en,
		input  flush_active, flush_step, flush_clear,
		output hit, dirty, flush_last
	);

endinterface

// ==== logic/cache_datapath.sv ====
`timescale 1ns/10ps

module cache_datapath (
	input  logic             clk,
	input  logic             n_rst,
	cache_ctrl_if.datapath   ctrl,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::word_t req_wdata,
	input  cache_pkg::word_t mem_rdata,
	output cache_pkg::word_t cpu_rdata,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata
);
	import cache_pkg::*;

	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;
	tag_t             tag_arr  [LINES];
	word_t            data_arr [LINES];

	tag_t   req_tag;
	index_t req_idx;
	index_t flush_idx;
	index_t idx;

	// byte offset is dropped, all accesses are whole words
	assign req_tag = req_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign req_idx = req_addr[OFFSET_BITS +: INDEX_WIDTH];

	// flush walk overrides the request index
	assign idx = ctrl.flush_active ? flush_idx : req_idx;

	assign ctrl.hit        = valid[idx] && (tag_arr[idx] == req_tag);
	assign ctrl.dirty      = valid[idx] && dirty[idx];
	assign ctrl.flush_last = (flush_idx == index_t'(LINES - 1));

	// valid bits
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			valid <= '0;
		end else if (ctrl.flush_clear) begin
			valid <= '0;
		end else if (ctrl.fill_en) begin
			valid[idx] <= 1'b1;
		end
	end

	// dirty bits, a fill always lands clean
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			dirty <= '0;
		end else if (ctrl.cpu_wr_en) begin
			dirty[idx] <= 1'b1;
		end else if (ctrl.fill_en || ctrl.clean_en) begin
			dirty[idx] <= 1'b0;
		end
	end

	// flush line counter
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			flush_idx <= '0;
		end else if (ctrl.flush_clear) begin
			flush_idx <= '0;
		end else if (ctrl.flush_step) begin
			flush_idx <= flush_idx + 1'b1;
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (ctrl.fill_en) begin
			tag_arr[idx]  <= req_tag;
			data_arr[idx] <= mem_rdata;
		end else if (ctrl.cpu_wr_en) begin
			data_arr[idx] <= req_wdata;
		end
	end

	// victim address on writeback, request line address otherwise
	assign mem_addr  = {ctrl.wb_sel ? tag_arr[idx] : req_tag, idx, {OFFSET_BITS{1'b0}}};
	assign mem_wdata = data_arr[idx];

	// a write answers with the word it stores
	assign cpu_rdata = ctrl.cpu_wr_en ? req_wdata : data_arr[idx];

	// no line update may land while the flush walk owns the index
	a_no_update_in_flush: assert property (
		@(posedge clk) disable iff (!n_rst)
		ctrl.flush_active |-> !(ctrl.fill_en || ctrl.cpu_wr_en)
	) else $error("line update during flush walk");

endmodule

// ==== logic/cache_controller.sv ====
`timescale 1ns/10ps

module cache_controller (
	input  logic             clk,
	input  logic             n_rst,
	cache_ctrl_if.controller ctrl,
	input  logic             cpu_req_valid,
	input  logic             cpu_req_write,
	input  cache_pkg::addr_t cpu_addr,
	input  cache_pkg::word_t cpu_wdata,
	output logic             cpu_rsp_valid,
	output logic             cpu_credit,
	input  logic             flush_req,
	output logic             flush_done,
	output logic             mem_req_valid,
	output logic             mem_req_write,
	input  logic             mem_rsp_valid,
	input  logic             mem_credit,
	output cache_pkg::addr_t req_addr,
	output cache_pkg::word_t req_wdata
);
	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	addr_t q_addr  [CPU_CREDITS];
	word_t q_wdata [CPU_CREDITS];
	logic  q_write [CPU_CREDITS];

	logic [QPTR_WIDTH-1:0] q_rd;
	logic [QPTR_WIDTH-1:0] q_wr;
	logic [QCNT_WIDTH-1:0] q_cnt;
	logic [MCNT_WIDTH-1:0] mem_cnt;

	logic cur_write;
	logic have_credit;
	logic start_flush;
	logic take_queue;
	logic take_direct;
	logic q_push;

	assign have_credit = (mem_cnt != '0);
	assign start_flush = (state == ST_IDLE) && flush_req;
	assign take_queue  = (state == ST_IDLE) && !flush_req && (q_cnt != '0);
	// empty queue in idle lets a new request skip the queue
	assign take_direct = (state == ST_IDLE) && !flush_req && (q_cnt == '0) && cpu_req_valid;
	assign q_push      = cpu_req_valid && !take_direct;

	// request queue
	always_ff @(posedge clk) begin
		if (q_push) begin
			q_addr[q_wr]  <= cpu_addr;
			q_wdata[q_wr] <= cpu_wdata;
			q_write[q_wr] <= cpu_req_write;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			q_rd  <= '0;
			q_wr  <= '0;
			q_cnt <= '0;
		end else begin
			if (q_push)
				q_wr <= q_wr + 1'b1;
			if (take_queue)
				q_rd <= q_rd + 1'b1;
			q_cnt <= q_cnt + QCNT_WIDTH'(q_push) - QCNT_WIDTH'(take_queue);
		end
	end

	// current request
	always_ff @(posedge clk) begin
		if (take_queue) begin
			req_addr  <= q_addr[q_rd];
			req_wdata <= q_wdata[q_rd];
			cur_write <= q_write[q_rd];
		end else if (take_direct) begin
			req_addr  <= cpu_addr;
			req_wdata <= cpu_wdata;
			cur_write <= cpu_req_write;
		end
	end

	// memory credits, one taken per issue
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			mem_cnt <= MCNT_WIDTH'(MEM_CREDITS);
		else
			mem_cnt <= mem_cnt + MCNT_WIDTH'(mem_credit) - MCNT_WIDTH'(mem_req_valid);
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state        = state;
		ctrl.fill_en      = 1'b0;
		ctrl.cpu_wr_en    = 1'b0;
		ctrl.wb_sel       = 1'b0;
		ctrl.clean_en     = 1'b0;
		ctrl.flush_active = 1'b0;
		ctrl.flush_step   = 1'b0;
		ctrl.flush_clear  = 1'b0;
		cpu_rsp_valid     = 1'b0;
		mem_req_valid     = 1'b0;
		mem_req_write     = 1'b0;
		flush_done        = 1'b0;
		case (state)
			ST_IDLE: begin
				if (start_flush)
					next_state = ST_FLUSH_SCAN;
				else if (take_queue || take_direct)
					next_state = ST_LOOKUP;
			end
			ST_LOOKUP: begin
				if (ctrl.hit) begin
					cpu_rsp_valid  = 1'b1;
					ctrl.cpu_wr_en = cur_write;
					next_state     = ST_IDLE;
				end else if (ctrl.dirty) begin
					next_state = ST_WRITEBACK;
				end else begin
					next_state = ST_FILL_REQ;
				end
			end
			ST_WRITEBACK: begin
				ctrl.wb_sel = 1'b1;
				if (have_credit) begin
					mem_req_valid = 1'b1;
					mem_req_write = 1'b1;
					ctrl.clean_en = 1'b1;
					next_state    = ST_FILL_REQ;
				end
			end
			ST_FILL_REQ: begin
				if (have_credit) begin
					mem_req_valid = 1'b1;
					next_state    = ST_FILL_WAIT;
				end
			end
			ST_FILL_WAIT: begin
				// back to lookup, which then hits and merges a write
				if (mem_rsp_valid) begin
					ctrl.fill_en = 1'b1;
					next_state   = ST_LOOKUP;
				end
			end
			ST_FLUSH_SCAN: begin
				ctrl.flush_active = 1'b1;
				if (ctrl.dirty)
					next_state = ST_FLUSH_WB;
				else if (ctrl.flush_last)
					next_state = ST_FLUSH_DONE;
				else
					ctrl.flush_step = 1'b1;
			end
			ST_FLUSH_WB: begin
				ctrl.flush_active = 1'b1;
				ctrl.wb_sel       = 1'b1;
				if (have_credit) begin
					mem_req_valid = 1'b1;
					mem_req_write = 1'b1;
					ctrl.clean_en = 1'b1;
					next_state    = ST_FLUSH_SCAN;
				end
			end
			ST_FLUSH_DONE: begin
				// all writebacks retired before done
				if (mem_cnt == MCNT_WIDTH'(MEM_CREDITS)) begin
					ctrl.flush_clear = 1'b1;
					flush_done       = 1'b1;
					next_state       = ST_IDLE;
				end
			end
			default: next_state = ST_IDLE;
		endcase
	end

	assign cpu_credit = cpu_rsp_valid;

	a_mem_issue_credit: assert property (
		@(posedge clk) disable iff (!n_rst)
		mem_req_valid |-> have_credit
	) else $error("memory request issued without credit");

	// memory returned more credits than it was given
	a_mem_credit_max: assert property (
		@(posedge clk) disable iff (!n_rst)
		mem_cnt <= MCNT_WIDTH'(MEM_CREDITS)
	) else $error("memory credit count above limit");

	// a returned credit leaves room for the request it frees
	a_cpu_credit_rsp: assert property (
		@(posedge clk) disable iff (!n_rst)
		cpu_credit |-> cpu_rsp_valid && (q_cnt < QCNT_WIDTH'(CPU_CREDITS))
	) else $error("cpu credit returned out of step with responses");

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/10ps

module cache_top (
	input  logic             clk,
	input  logic             n_rst,
	input  logic             cpu_req_valid,
	input  logic             cpu_req_write,
	input  cache_pkg::addr_t cpu_addr,
	input  cache_pkg::word_t cpu_wdata,
	output logic             cpu_rsp_valid,
	output logic             cpu_credit,
	output cache_pkg::word_t cpu_rdata,
	input  logic             flush_req,
	output logic             flush_done,
	output logic             mem_req_valid,
	output logic             mem_req_write,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata,
	input  logic             mem_rsp_valid,
	input  logic             mem_credit,
	input  cache_pkg::word_t mem_rdata
);
	import cache_pkg::*;

	// current request from controller to datapath
	addr_t req_addr;
	word_t req_wdata;

	cache_ctrl_if ctrl_bus ();

	cache_controller u_controller (
		.clk           (clk),
		.n_rst         (n_rst),
		.ctrl          (ctrl_bus.controller),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_write (cpu_req_write),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_rsp_valid (cpu_rsp_valid),
		.cpu_credit    (cpu_credit),
		.flush_req     (flush_req),
		.flush_done    (flush_done),
		.mem_req_valid (mem_req_valid),
		.mem_req_write (mem_req_write),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_credit    (mem_credit),
		.req_addr      (req_addr),
		.req_wdata     (req_wdata)
	);

	cache_datapath u_datapath (
		.clk       (clk),
		.n_rst     (n_rst),
		.ctrl      (ctrl_bus.datapath),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.mem_rdata (mem_rdata),
		.cpu_rdata (cpu_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic n_rst
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset low for 8 cycles, released on a falling edge
	initial begin
		n_rst = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		n_rst = 1'b1;
	end

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/10ps

module mem_model (
	input  logic             clk,
	input  logic             n_rst,
	input  logic             req_valid,
	input  logic             req_write,
	input  cache_pkg::addr_t addr,
	input  cache_pkg::word_t wdata,
	input  logic [1:0]       delay,
	output logic             rsp_valid,
	output logic             credit,
	output cache_pkg::word_t rdata
);
	import cache_pkg::*;

	localparam int WORDS = 256;

	word_t       mem [WORDS];
	logic [7:0]  pend_idx [$];
	logic        pend_write [$];
	int          pend_wait [$];

	// power-up contents, every address bit takes part
	function automatic word_t fill_word(input addr_t a);
		return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = fill_word(addr_t'(i) << 2);
		rsp_valid = 1'b0;
		credit    = 1'b0;
		rdata     = '0;
	end

	// requests taken at the rising edge, writes land at once
	always @(posedge clk) begin
		if (n_rst && req_valid) begin
			pend_idx.push_back(addr[9:2]);
			pend_write.push_back(req_write);
			pend_wait.push_back(int'(delay));
			if (req_write)
				mem[addr[9:2]] = wdata;
		end
	end

	// retire in order, one per cycle, after the drawn delay
	always @(negedge clk) begin
		rsp_valid = 1'b0;
		credit    = 1'b0;
		if (n_rst && pend_idx.size() != 0) begin
			if (pend_wait[0] == 0) begin
				credit = 1'b1;
				if (!pend_write[0]) begin
					rsp_valid = 1'b1;
					rdata     = mem[pend_idx[0]];
				end
				pend_idx.delete(0);
				pend_write.delete(0);
				pend_wait.delete(0);
			end else begin
				pend_wait[0] = pend_wait[0] - 1;
			end
		end
	end

endmodule

// ==== tests/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb;
	import cache_pkg::*;

	localparam int WORDS   = 256;
	localparam int TIMEOUT = 500;

	logic       clk;
	logic       n_rst;
	logic       cpu_req_valid;
	logic       cpu_req_write;
	addr_t      cpu_addr;
	word_t      cpu_wdata;
	logic       cpu_rsp_valid;
	logic       cpu_credit;
	word_t      cpu_rdata;
	logic       flush_req;
	logic       flush_done;
	logic       mem_req_valid;
	logic       mem_req_write;
	addr_t      mem_addr;
	word_t      mem_wdata;
	logic       mem_rsp_valid;
	logic       mem_credit;
	word_t      mem_rdata;
	logic [1:0] mem_delay;

	// memory as the CPU should see it
	word_t image [WORDS];
	bit    written [WORDS];

	// requests in flight with the oldest first
	logic  pend_write [$];
	addr_t pend_addr [$];
	word_t pend_wdata [$];
	// victim addresses expected on the next memory writes
	addr_t wb_expect [$];

	int          credits;
	int          outstanding;
	int          mem_reqs;
	int          mem_writes;
	int          flushes;
	logic [15:0] rng;
	logic [15:0] dly_rng;
	logic [31:0] dly_bits;

	tb_clock clock_gen (.clk(clk), .n_rst(n_rst));

	mem_model memory (
		.clk       (clk),
		.n_rst     (n_rst),
		.req_valid (mem_req_valid),
		.req_write (mem_req_write),
		.addr      (mem_addr),
		.wdata     (mem_wdata),
		.delay     (mem_delay),
		.rsp_valid (mem_rsp_valid),
		.credit    (mem_credit),
		.rdata     (mem_rdata)
	);

	cache_top DUT (
		.clk           (clk),
		.n_rst         (n_rst),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_write (cpu_req_write),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_rsp_valid (cpu_rsp_valid),
		.cpu_credit    (cpu_credit),
		.cpu_rdata     (cpu_rdata),
		.flush_req     (flush_req),
		.flush_done    (flush_done),
		.mem_req_valid (mem_req_valid),
		.mem_req_write (mem_req_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_credit    (mem_credit),
		.mem_rdata     (mem_rdata)
	);

	function automatic logic [15:0] galois_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step per bit
	task automatic draw(input int n, inout logic [15:0] s, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			s = galois_step(s);
			v = {v[30:0], s[0]};
		end
	endtask

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// last written word, else the power-up pattern
	function automatic word_t ref_access(input logic wr, input addr_t a, input word_t d);
		int i;
		i = int'(a[9:2]);
		if (wr) begin
			image[i]   = d;
			written[i] = 1'b1;
		end
		return written[i] ? image[i] : memory.fill_word(a);
	endfunction

	task automatic check_mem_write();
		addr_t exp_addr;
		if (wb_expect.size() != 0) begin
			exp_addr = wb_expect[0];
			wb_expect.delete(0);
			check_addr("mem_addr", mem_addr, exp_addr);
		end
		if (mem_addr[ADDR_WIDTH-1:10] != '0 || mem_addr[1:0] != '0 || !written[mem_addr[9:2]])
			stop_run("memory write to an address the CPU never wrote");
		else
			check_word("mem_wdata", mem_wdata, image[mem_addr[9:2]]);
	endtask

	// one request for one cycle once a credit is held
	task automatic send(input logic wr, input addr_t a, input word_t d);
		int t;
		t = 0;
		while (credits == 0) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				stop_run("timed out waiting for a CPU credit");
		end
		cpu_req_valid = 1'b1;
		cpu_req_write = wr;
		cpu_addr      = a;
		cpu_wdata     = d;
		credits--;
		pend_write.push_back(wr);
		pend_addr.push_back(a);
		pend_wdata.push_back(d);
		@(negedge clk);
		cpu_req_valid = 1'b0;
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (pend_addr.size() != 0 || outstanding != 0) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				stop_run("timed out waiting for requests in flight to finish");
		end
	endtask

	task automatic do_flush(output int wb_count);
		int t;
		int w0;
		int f0;
		w0        = mem_writes;
		f0        = flushes;
		flush_req = 1'b1;
		@(negedge clk);
		flush_req = 1'b0;
		t = 0;
		while (flushes == f0) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				stop_run("timed out waiting for flush_done");
		end
		wb_count = mem_writes - w0;
	endtask

	// memory delay for the next request
	initial begin
		@(posedge clk);
		forever begin
			@(negedge clk);
			draw(2, dly_rng, dly_bits);
			mem_delay = dly_bits[1:0];
		end
	end

	// response and memory port checks
	always @(posedge clk) begin
		if (n_rst) begin
			if (cpu_rsp_valid) begin
				if (pend_addr.size() == 0) begin
					stop_run("response from the cache with no request in flight");
				end else begin
					check_word("cpu_rdata", cpu_rdata,
						ref_access(pend_write[0], pend_addr[0], pend_wdata[0]));
					pend_write.delete(0);
					pend_addr.delete(0);
					pend_wdata.delete(0);
				end
			end
			check_flag("cpu_credit", cpu_credit, cpu_rsp_valid);
			if (cpu_credit)
				credits++;
			if (flush_done)
				flushes++;
			if (mem_credit)
				outstanding--;
			if (mem_req_valid) begin
				outstanding++;
				mem_reqs++;
				if (mem_req_write) begin
					mem_writes++;
					check_mem_write();
				end
			end
			if (outstanding > MEM_CREDITS || outstanding < 0)
				stop_run("outstanding memory requests out of the credit range");
		end
	end

	initial begin
		int          n;
		int          t;
		int          r0;
		int          w0;
		logic [31:0] bits;
		logic        wr;
		logic [5:0]  widx;
		rng           = 16'd9047;
		dly_rng       = 16'd9047;
		mem_delay     = 2'd0;
		cpu_req_valid = 1'b0;
		cpu_req_write = 1'b0;
		cpu_addr      = '0;
		cpu_wdata     = '0;
		flush_req     = 1'b0;
		credits       = CPU_CREDITS;
		outstanding   = 0;
		mem_reqs      = 0;
		mem_writes    = 0;
		flushes       = 0;
		t             = 0;
		while (n_rst !== 1'b1) begin
			@(posedge clk);
			t++;
			if (t > 50)
				stop_run("reset was never released");
		end
		@(negedge clk);
		check_flag("cpu_rsp_valid", cpu_rsp_valid, 1'b0);
		check_flag("cpu_credit", cpu_credit, 1'b0);
		check_flag("mem_req_valid", mem_req_valid, 1'b0);
		check_flag("flush_done", flush_done, 1'b0);

		// cold miss, then a hit one cycle after acceptance
		r0 = mem_reqs;
		send(1'b0, 32'h104, '0);
		drain();
		if (mem_reqs - r0 != 1)
			stop_run("read miss did not issue exactly one memory request");
		r0 = mem_reqs;
		send(1'b0, 32'h104, '0);
		check_flag("cpu_rsp_valid", cpu_rsp_valid, 1'b1);
		drain();
		if (mem_reqs != r0)
			stop_run("read hit went to memory");

		// write then read back with nothing written to memory
		w0 = mem_writes;
		send(1'b1, 32'h108, 32'hC0DE_0108);
		send(1'b0, 32'h108, '0);
		drain();
		if (mem_writes != w0)
			stop_run("write allocate or read hit wrote to memory");

		// a new tag at the same index evicts the dirty word
		wb_expect.push_back(32'h108);
		w0 = mem_writes;
		r0 = mem_reqs;
		send(1'b0, 32'h148, '0);
		drain();
		if (mem_writes - w0 != 1 || mem_reqs - r0 != 2 || wb_expect.size() != 0)
			stop_run("dirty eviction did not write back once and then fill");

		// flush writes back dirty lines in index order
		send(1'b1, 32'h10C, 32'h1111_010C);
		send(1'b1, 32'h114, 32'h2222_0114);
		send(1'b1, 32'h130, 32'h3333_0130);
		drain();
		wb_expect.push_back(32'h10C);
		wb_expect.push_back(32'h114);
		wb_expect.push_back(32'h130);
		do_flush(n);
		if (n != 3)
			stop_run($sformatf("flush wrote back %0d lines instead of 3", n));
		r0 = mem_reqs;
		w0 = mem_writes;
		send(1'b0, 32'h114, '0);
		drain();
		if (mem_reqs - r0 != 1 || mem_writes != w0)
			stop_run("read after flush did not miss and fill");

		// random traffic over 64 words
		for (int k = 0; k < 300; k++) begin
			draw(2, rng, bits);
			if (bits[1:0] == 2'b00)
				@(negedge clk);
			draw(1, rng, bits);
			wr = bits[0];
			draw(6, rng, bits);
			widx = bits[5:0];
			draw(32, rng, bits);
			send(wr, addr_t'({widx, 2'b00}), bits);
		end
		drain();
		do_flush(n);
		drain();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
logic/cache_pkg.sv
logic/cache_ctrl_if.sv
logic/cache_datapath.sv
logic/cache_controller.sv
logic/cache_top.sv
tests/tb_clock.sv
tests/mem_model.sv
tests/cache_tb.sv
